/* Makefile */
# Verilator build for the n64 loader testbench

VERILATOR ?= verilator
TOP       ?= tb_n64_loader
FILELIST  ?= n64_loader.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= Regression passed
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hw/backup_control.sv */
// Backup memory control

`timescale 1ns/1ps

module backup_control (
	input  logic                                 clk_1x,
	input  logic                                 rst_n,
	input  loader_pkg::region_e                  region,
	input  logic                                 load_req,
	input  logic                                 save_req,
	input  logic                                 autosave_off,
	input  logic                                 osd_open,
	input  logic                                 img_mounted,
	input  logic                                 img_readonly,
	input  logic [loader_pkg::img_size_w-1:0]    img_size,
	input  loader_pkg::save_type_e               save_type,
	input  logic                                 bk_pending,
	output logic                                 bk_load,
	output logic                                 bk_save,
	output logic                                 use_img,
	output loader_pkg::eeprom_kind_e             eeprom_kind,
	output logic                                 led_user
);

	logic cart_region;
	logic cart_q;
	logic osd_q;

	assign cart_region = (region == loader_pkg::region_cart);

	//======================================================================
	// Save engine triggers
	//======================================================================

	always_ff @(posedge clk_1x or negedge rst_n) begin
		if (!rst_n) begin
			cart_q  <= 1'b0;
			osd_q   <= 1'b0;
			bk_load <= 1'b0;
			bk_save <= 1'b0;
			use_img <= 1'b0;
		end else begin
			cart_q  <= cart_region;
			osd_q   <= osd_open;
			bk_load <= load_req | (cart_region & img_mounted);
			// Autosave when the menu opens
			bk_save <= save_req | (osd_open & ~osd_q & ~autosave_off);
			// New cartridge forgets the old image; a mount in the same cycle wins
			if (cart_region && !cart_q) begin
				use_img <= 1'b0;
			end
			if (img_mounted && (img_size != '0) && !img_readonly) begin
				use_img <= 1'b1;
			end
		end
	end

	always_comb begin
		case (save_type)
			loader_pkg::save_eeprom4:  eeprom_kind = loader_pkg::eeprom_4k;
			loader_pkg::save_eeprom16: eeprom_kind = loader_pkg::eeprom_16k;
			default:                   eeprom_kind = loader_pkg::eeprom_off;
		endcase
	end

	assign led_user = cart_region | bk_pending;

endmodule

/* hw/cart_write_port.sv */
// Cartridge RAM write port

`timescale 1ns/1ps

module cart_write_port #(
	parameter logic [loader_pkg::host_addr_w-1:0] cart_base = loader_pkg::cart_base_default
) (
	input  logic                                 clk_1x,
	input  logic                                 rst_n,
	input  loader_pkg::region_e                  region,
	input  logic                                 pk_wr,
	input  logic [loader_pkg::host_addr_w-1:0]   pk_addr,
	input  logic [loader_pkg::word_w-1:0]        pk_data,
	input  logic                                 ram_ready,
	output logic                                 ram_req,
	output logic [loader_pkg::host_addr_w-1:0]   ram_addr,
	output logic [loader_pkg::word_w-1:0]        ram_data,
	output logic                                 dl_wait,
	output logic                                 cart_loaded
);

	logic in_cart;
	logic wait_q;

	assign in_cart = (region == loader_pkg::region_cart);

	//======================================================================
	// RAM request
	//======================================================================

	// Request leaves in the cycle the word is complete
	assign ram_req  = pk_wr;
	assign ram_addr = pk_addr + cart_base;
	assign ram_data = pk_data;

	//======================================================================
	// Host hold-off
	//======================================================================

	// Held from the request until RAM confirms
	always_ff @(posedge clk_1x or negedge rst_n) begin
		if (!rst_n) begin
			wait_q <= 1'b0;
		end else if (!in_cart) begin
			wait_q <= 1'b0;
		end else if (pk_wr) begin
			wait_q <= 1'b1;
		end else if (ram_ready) begin
			wait_q <= 1'b0;
		end
	end

	// Request cycle counts too; drop as soon as download ends
	assign dl_wait = in_cart & (pk_wr | wait_q);

	// Sticky once any cartridge download starts
	always_ff @(posedge clk_1x or negedge rst_n) begin
		if (!rst_n) begin
			cart_loaded <= 1'b0;
		end else if (in_cart) begin
			cart_loaded <= 1'b1;
		end
	end

endmodule

/* hw/download_decode.sv */
// Download slot decode stage

`timescale 1ns/1ps

module download_decode (
	input  logic                                 clk_1x,
	input  logic                                 rst_n,
	input  logic                                 dl_active,
	input  logic [loader_pkg::slot_w-1:0]        dl_index,
	input  logic                                 dl_wr,
	input  logic [loader_pkg::host_addr_w-1:0]   dl_addr,
	input  logic [loader_pkg::host_data_w-1:0]   dl_data,
	output loader_pkg::region_e                  region,
	output logic                                 dec_bank,
	output logic                                 dec_wr,
	output logic [loader_pkg::host_addr_w-1:0]   dec_addr,
	output logic [loader_pkg::host_data_w-1:0]   dec_data
);

	loader_pkg::region_e region_d;

	//======================================================================
	// Slot classification
	//======================================================================

	// Only the low six index bits select the target
	always_comb begin
		region_d = loader_pkg::region_none;
		if (dl_active) begin
			case (dl_index[5:0])
				loader_pkg::slot_pif:  region_d = loader_pkg::region_pif;
				loader_pkg::slot_cart: region_d = loader_pkg::region_cart;
				default:               region_d = loader_pkg::region_none;
			endcase
		end
	end

	//======================================================================
	// Host word register
	//======================================================================

	always_ff @(posedge clk_1x or negedge rst_n) begin
		if (!rst_n) begin
			region <= loader_pkg::region_none;
			dec_wr <= 1'b0;
		end else begin
			region <= region_d;
			dec_wr <= dl_wr;
		end
	end

	// Payload travels alongside dec_wr
	always_ff @(posedge clk_1x) begin
		dec_bank <= dl_index[6];
		dec_addr <= dl_addr;
		dec_data <= dl_data;
	end

endmodule

/* hw/loader_pkg.sv */
// Loader shared definitions

package loader_pkg;

	//======================================================================
	// Widths
	//======================================================================

	// Host byte address, also used as RAM byte address
	localparam int host_addr_w = 27;
	localparam int host_data_w = 16;
	localparam int word_w      = 32;

	// Boot ROM holds 1024 words
	localparam int pif_addr_w  = 10;
	localparam int slot_w      = 8;

	// Mounted image size as reported by the host
	localparam int img_size_w  = 32;

	//======================================================================
	// Encodings
	//======================================================================

	typedef enum logic [1:0] {
		region_none = 2'd0,
		region_pif  = 2'd1,
		region_cart = 2'd2
	} region_e;

	// Order follows the menu entry
	typedef enum logic [2:0] {
		save_none,
		save_eeprom4,
		save_eeprom16,
		save_sram32,
		save_sram96,
		save_flash
	} save_type_e;

	typedef enum logic [1:0] {
		eeprom_off,
		eeprom_4k,
		eeprom_16k
	} eeprom_kind_e;

	// Slot codes in dl_index[5:0]
	localparam logic [5:0] slot_pif  = 6'd0;
	localparam logic [5:0] slot_cart = 6'd1;

	// Cartridge image starts 8 MB into RAM
	localparam logic [host_addr_w-1:0] cart_base_default = 27'd8388608;

endpackage

/* hw/n64_loader_top.sv */
// ROM download and backup front end

`timescale 1ns/1ps

module n64_loader_top #(
	parameter logic [loader_pkg::host_addr_w-1:0] cart_base = loader_pkg::cart_base_default
) (
	input  logic                                 clk_1x,
	input  logic                                 rst_n,
	// Host download
	input  logic                                 dl_active,
	input  logic [loader_pkg::slot_w-1:0]        dl_index,
	input  logic                                 dl_wr,
	input  logic [loader_pkg::host_addr_w-1:0]   dl_addr,
	input  logic [loader_pkg::host_data_w-1:0]   dl_data,
	output logic                                 dl_wait,
	// Boot ROM write port
	output logic                                 pif_wren,
	output logic [loader_pkg::pif_addr_w-1:0]    pif_addr,
	output logic [loader_pkg::word_w-1:0]        pif_data,
	// RAM write channel
	output logic                                 ram_req,
	output logic [loader_pkg::host_addr_w-1:0]   ram_addr,
	output logic [loader_pkg::word_w-1:0]        ram_data,
	input  logic                                 ram_ready,
	output logic                                 cart_loaded,
	// Backup memory
	input  logic                                 load_req,
	input  logic                                 save_req,
	input  logic                                 autosave_off,
	input  logic                                 osd_open,
	input  logic                                 img_mounted,
	input  logic                                 img_readonly,
	input  logic [loader_pkg::img_size_w-1:0]    img_size,
	input  loader_pkg::save_type_e               save_type,
	input  logic                                 bk_pending,
	output logic                                 bk_load,
	output logic                                 bk_save,
	output logic                                 use_img,
	output loader_pkg::eeprom_kind_e             eeprom_kind,
	output logic                                 led_user
);

	loader_pkg::region_e                region;
	logic                               dec_bank;
	logic                               dec_wr;
	logic [loader_pkg::host_addr_w-1:0] dec_addr;
	logic [loader_pkg::host_data_w-1:0] dec_data;
	logic                               pk_wr;
	logic [loader_pkg::host_addr_w-1:0] pk_addr;
	logic [loader_pkg::word_w-1:0]      pk_data;

	//======================================================================
	// Download pipeline
	//======================================================================

	download_decode i_decode (
		.clk_1x    (clk_1x),
		.rst_n     (rst_n),
		.dl_active (dl_active),
		.dl_index  (dl_index),
		.dl_wr     (dl_wr),
		.dl_addr   (dl_addr),
		.dl_data   (dl_data),
		.region    (region),
		.dec_bank  (dec_bank),
		.dec_wr    (dec_wr),
		.dec_addr  (dec_addr),
		.dec_data  (dec_data)
	);

	word_packer i_packer (
		.clk_1x    (clk_1x),
		.rst_n     (rst_n),
		.region    (region),
		.dec_bank  (dec_bank),
		.dec_wr    (dec_wr),
		.dec_addr  (dec_addr),
		.dec_data  (dec_data),
		.pif_wren  (pif_wren),
		.pif_addr  (pif_addr),
		.pif_data  (pif_data),
		.pk_wr     (pk_wr),
		.pk_addr   (pk_addr),
		.pk_data   (pk_data)
	);

	cart_write_port #(
		.cart_base (cart_base)
	) i_cart_port (
		.clk_1x      (clk_1x),
		.rst_n       (rst_n),
		.region      (region),
		.pk_wr       (pk_wr),
		.pk_addr     (pk_addr),
		.pk_data     (pk_data),
		.ram_ready   (ram_ready),
		.ram_req     (ram_req),
		.ram_addr    (ram_addr),
		.ram_data    (ram_data),
		.dl_wait     (dl_wait),
		.cart_loaded (cart_loaded)
	);

	// Runs beside the pipeline
	backup_control i_backup (
		.clk_1x       (clk_1x),
		.rst_n        (rst_n),
		.region       (region),
		.load_req     (load_req),
		.save_req     (save_req),
		.autosave_off (autosave_off),
		.osd_open     (osd_open),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.img_size     (img_size),
		.save_type    (save_type),
		.bk_pending   (bk_pending),
		.bk_load      (bk_load),
		.bk_save      (bk_save),
		.use_img      (use_img),
		.eeprom_kind  (eeprom_kind),
		.led_user     (led_user)
	);

endmodule

/* hw/word_packer.sv */
// Half-word to word packer

`timescale 1ns/1ps

module word_packer (
	input  logic                                 clk_1x,
	input  logic                                 rst_n,
	input  loader_pkg::region_e                  region,
	input  logic                                 dec_bank,
	input  logic                                 dec_wr,
	input  logic [loader_pkg::host_addr_w-1:0]   dec_addr,
	input  logic [loader_pkg::host_data_w-1:0]   dec_data,
	output logic                                 pif_wren,
	output logic [loader_pkg::pif_addr_w-1:0]    pif_addr,
	output logic [loader_pkg::word_w-1:0]        pif_data,
	output logic                                 pk_wr,
	output logic [loader_pkg::host_addr_w-1:0]   pk_addr,
	output logic [loader_pkg::word_w-1:0]        pk_data
);

	logic [loader_pkg::host_data_w-1:0] lo_half;
	logic [loader_pkg::host_data_w-1:0] hi_half;
	logic                               is_pif;
	logic                               is_cart;
	logic                               wr_lo;
	logic                               wr_hi;

	assign is_pif  = (region == loader_pkg::region_pif);
	assign is_cart = (region == loader_pkg::region_cart);

	// Address bit 1 tells lower from upper half
	assign wr_lo = dec_wr & ~dec_addr[1];
	assign wr_hi = dec_wr & dec_addr[1];

	//======================================================================
	// Half-word and address capture
	//======================================================================

	always_ff @(posedge clk_1x) begin
		if (wr_lo && (is_pif || is_cart)) begin
			lo_half <= dec_data;
		end
		if (wr_hi && (is_pif || is_cart)) begin
			hi_half <= dec_data;
		end
		// Boot ROM word index with bank select on top
		if (wr_lo && is_pif) begin
			pif_addr <= {dec_bank, dec_addr[10:2]};
		end
		if (wr_lo && is_cart) begin
			pk_addr <= dec_addr;
		end
	end

	//======================================================================
	// Word strobes
	//======================================================================

	always_ff @(posedge clk_1x or negedge rst_n) begin
		if (!rst_n) begin
			pif_wren <= 1'b0;
			pk_wr    <= 1'b0;
		end else begin
			pif_wren <= wr_hi & is_pif;
			pk_wr    <= wr_hi & is_cart;
		end
	end

	// Boot ROM wants big-endian bytes
	assign pif_data = {lo_half[7:0], lo_half[15:8], hi_half[7:0], hi_half[15:8]};

	// Cartridge word keeps host order
	assign pk_data = {hi_half, lo_half};

endmodule

/* n64_loader.f */
hw/loader_pkg.sv
hw/download_decode.sv
hw/word_packer.sv
hw/cart_write_port.sv
hw/backup_control.sv
hw/n64_loader_top.sv
tests/tb_clock_gen.sv
tests/n64_loader_props.sv
tests/tb_n64_loader.sv

/* tests/n64_loader_props.sv */
// RAM handshake properties

`timescale 1ns/1ps

module n64_loader_props (
	input logic clk_1x,
	input logic rst_n,
	input logic ram_req,
	input logic ram_ready,
	input logic dl_wait
);

	req_one_cycle: assert property (@(posedge clk_1x) disable iff (!rst_n)
		ram_req |=> !ram_req)
		else $error("ram_req held for more than one cycle");

	wait_with_req: assert property (@(posedge clk_1x) disable iff (!rst_n)
		ram_req |-> dl_wait)
		else $error("dl_wait low during ram_req");

	// Hold-off lasts until RAM answers
	wait_until_ready: assert property (@(posedge clk_1x) disable iff (!rst_n)
		(dl_wait && !ram_ready) |=> dl_wait)
		else $error("dl_wait dropped before ram_ready");

	wait_in_reset: assert property (@(posedge clk_1x)
		!rst_n |-> !dl_wait)
		else $error("dl_wait high during reset");

endmodule

bind cart_write_port n64_loader_props i_props (
	.clk_1x    (clk_1x),
	.rst_n     (rst_n),
	.ram_req   (ram_req),
	.ram_ready (ram_ready),
	.dl_wait   (dl_wait)
);

/* tests/n64_loader_stimulus.txt */
# test command op0 op1 op2 op3 op4 op5, operands in hex
# pif: index addr lo hi pif_addr pif_data / cart: addr lo hi ram_addr ram_data use_img
pif_bank0 pif 00 0000010 1234 abcd 004 3412cdab
pif_bank1 pif 40 00007f8 a55a 0ff0 3fe 5aa5f00f
cart_first cart 0000000 1111 2222 0800000 22221111 0
load_menu backup 1 0 1 0 0 0
mount_rw backup 2 0 1 100 0 1
cart_new cart 0000004 beef dead 0800004 deadbeef 0
mount_ro backup 2 0 1 100 1 0
cart_high cart 0123458 f00d cafe 0923458 cafef00d 0
osd_auto backup 3 0 1 0 0 0
osd_noauto backup 3 1 0 0 0 0
st_none savetype 0 0 0 0 0 0
st_eep4 savetype 1 1 0 0 0 0
st_eep16 savetype 2 2 0 0 0 0
st_sram32 savetype 3 0 0 0 0 0
st_sram96 savetype 4 0 0 0 0 0
st_flash savetype 5 0 0 0 0 0

/* tests/tb_clock_gen.sv */
// Testbench clock and reset

`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int half_period  = 4,
	parameter int reset_cycles = 8
) (
	output logic clk_1x,
	output logic rst_n
);

	initial begin
		clk_1x = 1'b0;
		forever #(half_period) clk_1x = ~clk_1x;
	end

	// Reset released on a rising edge
	initial begin
		rst_n = 1'b0;
		repeat (reset_cycles) @(posedge clk_1x);
		rst_n <= 1'b1;
	end

endmodule

/* tests/tb_n64_loader.sv */
// Loader testbench top

`timescale 1ns/1ps

module tb_n64_loader;

	localparam int max_lines       = 32;
	localparam int cycles_per_line = 200;

	logic clk_1x, rst_n;
	logic dl_active, dl_wr, ram_ready, load_req, save_req, autosave_off;
	logic osd_open, img_mounted, img_readonly, bk_pending;
	logic [loader_pkg::slot_w-1:0]      dl_index;
	logic [loader_pkg::host_addr_w-1:0] dl_addr;
	logic [loader_pkg::host_data_w-1:0] dl_data;
	logic [loader_pkg::img_size_w-1:0]  img_size;
	loader_pkg::save_type_e             save_type;
	logic dl_wait, pif_wren, ram_req, cart_loaded, bk_load, bk_save, use_img, led_user;
	logic [loader_pkg::pif_addr_w-1:0]  pif_addr;
	logic [loader_pkg::word_w-1:0]      pif_data, ram_data;
	logic [loader_pkg::host_addr_w-1:0] ram_addr;
	loader_pkg::eeprom_kind_e           eeprom_kind;

	logic [8*16-1:0] name_tab [max_lines];
	logic [8*16-1:0] cmd_tab [max_lines];
	logic [31:0]     arg_tab [max_lines][6];
	int              n_lines = 0;
	bit              loaded = 1'b0;
	int              req_count = 0;
	int              pairs_sent = 0;
	logic [31:0]     lcg_state = 32'h8782_975b;

	tb_clock_gen i_clk (.clk_1x(clk_1x), .rst_n(rst_n));

	n64_loader_top #(.cart_base(loader_pkg::cart_base_default)) i_dut (.*);

	//======================================================================
	// Helpers
	//======================================================================

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic report_failure(input string why);
		$display("%s", why);
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic check(input logic [8*16-1:0] name, input logic [31:0] exp,
			input logic [31:0] act);
		assert (exp === act) else begin
			$display("MISMATCH %0s expected %h actual %h", name, exp, act);
			report_failure("value check failed");
		end
	endtask

	task automatic load_stimulus();
		int fd;
		int rc;
		logic [8*128-1:0] text;
		logic [8*16-1:0]  nm, cm;
		logic [31:0]      v0, v1, v2, v3, v4, v5;
		fd = $fopen("tests/n64_loader_stimulus.txt", "r");
		if (fd == 0) report_failure("could not open the stimulus file");
		while (!$feof(fd) && n_lines < max_lines) begin
			text = '0;
			rc = $fgets(text, fd);
			rc = $sscanf(text, "%s %s %h %h %h %h %h %h", nm, cm, v0, v1, v2, v3, v4, v5);
			// Comment and blank lines do not parse fully
			if (rc == 8) begin
				name_tab[n_lines] = nm;
				cmd_tab[n_lines]  = cm;
				arg_tab[n_lines]  = '{v0, v1, v2, v3, v4, v5};
				n_lines++;
			end
		end
		$fclose(fd);
	endtask

	task automatic host_write(input logic [31:0] addr, input logic [31:0] data);
		@(posedge clk_1x);
		dl_addr <= addr[loader_pkg::host_addr_w-1:0];
		dl_data <= data[loader_pkg::host_data_w-1:0];
		dl_wr   <= 1'b1;
		@(posedge clk_1x);
		dl_wr   <= 1'b0;
	endtask

	// Boot ROM word must appear exactly two cycles after the upper strobe
	task automatic pif_download(input int i);
		@(posedge clk_1x);
		dl_active <= 1'b1;
		dl_index  <= arg_tab[i][0][7:0];
		host_write(arg_tab[i][1], arg_tab[i][2]);
		host_write(arg_tab[i][1] | 32'd2, arg_tab[i][3]);
		@(negedge clk_1x);
		check(name_tab[i], 32'd0, 32'(pif_wren));
		@(negedge clk_1x);
		check(name_tab[i], 32'd1, 32'(pif_wren));
		check(name_tab[i], arg_tab[i][4], 32'(pif_addr));
		check(name_tab[i], arg_tab[i][5], pif_data);
		@(negedge clk_1x);
		check(name_tab[i], 32'd0, 32'(pif_wren));
		@(posedge clk_1x);
		dl_active <= 1'b0;
	endtask

	task automatic cart_download(input int i);
		@(posedge clk_1x);
		dl_active <= 1'b1;
		dl_index  <= 8'd1;
		host_write(arg_tab[i][0], arg_tab[i][1]);
		host_write(arg_tab[i][0] | 32'd2, arg_tab[i][2]);
		pairs_sent++;
		@(negedge clk_1x);
		while (!ram_req) @(negedge clk_1x);
		check(name_tab[i], arg_tab[i][3], 32'(ram_addr));
		check(name_tab[i], arg_tab[i][4], ram_data);
		check(name_tab[i], 32'd1, 32'(dl_wait));
		// LED follows the cartridge download
		check(name_tab[i], 32'd1, 32'(led_user));
		@(negedge clk_1x);
		while (!ram_ready) begin
			check(name_tab[i], 32'd1, 32'(dl_wait));
			@(negedge clk_1x);
		end
		check(name_tab[i], 32'd1, 32'(dl_wait));
		@(negedge clk_1x);
		check(name_tab[i], 32'd0, 32'(dl_wait));
		check(name_tab[i], 32'd1, 32'(cart_loaded));
		check(name_tab[i], arg_tab[i][5], 32'(use_img));
		@(posedge clk_1x);
		dl_active <= 1'b0;
	endtask

	task automatic count_pulses(input bit on_save, output int n);
		n = 0;
		repeat (8) begin
			@(negedge clk_1x);
			n += on_save ? int'(bk_save) : int'(bk_load);
		end
	endtask

	task automatic backup_sequence(input int i);
		int n;
		case (arg_tab[i][0])
			32'd1: begin
				@(posedge clk_1x) load_req <= 1'b1;
				@(posedge clk_1x) load_req <= 1'b0;
				count_pulses(1'b0, n);
			end
			32'd2: begin
				@(posedge clk_1x);
				dl_active <= 1'b1;
				dl_index  <= 8'd1;
				repeat (2) @(posedge clk_1x);
				img_size     <= arg_tab[i][3];
				img_readonly <= arg_tab[i][4][0];
				img_mounted  <= 1'b1;
				@(posedge clk_1x) img_mounted <= 1'b0;
				count_pulses(1'b0, n);
				check(name_tab[i], arg_tab[i][5], 32'(use_img));
				@(posedge clk_1x) dl_active <= 1'b0;
			end
			default: begin
				@(posedge clk_1x);
				autosave_off <= arg_tab[i][1][0];
				osd_open     <= 1'b1;
				count_pulses(1'b1, n);
				@(posedge clk_1x) osd_open <= 1'b0;
				repeat (3) @(posedge clk_1x);
			end
		endcase
		check(name_tab[i], arg_tab[i][2], 32'(n));
	endtask

	task automatic save_type_decode(input int i);
		@(posedge clk_1x);
		save_type <= loader_pkg::save_type_e'(arg_tab[i][0][2:0]);
		@(negedge clk_1x);
		check(name_tab[i], arg_tab[i][1], 32'(eeprom_kind));
	endtask

	//======================================================================
	// RAM responder, request monitor and watchdog
	//======================================================================

	initial begin
		int delay;
		ram_ready = 1'b0;
		forever begin
			@(posedge clk_1x);
			ram_ready <= 1'b0;
			if (ram_req) begin
				lcg_state = lcg_next(lcg_state);
				delay = int'((lcg_state >> 16) % 32'd6) + 1;
				repeat (delay - 1) @(posedge clk_1x);
				ram_ready <= 1'b1;
			end
		end
	end

	always @(negedge clk_1x) begin
		if (ram_req) req_count++;
	end

	initial begin
		wait (loaded);
		repeat ((n_lines + 1) * cycles_per_line) @(posedge clk_1x);
		report_failure("watchdog timeout, the stimulus did not complete");
	end

	//======================================================================
	// Main sequence
	//======================================================================

	initial begin
		dl_active = 1'b0;
		dl_index = '0;
		dl_wr = 1'b0;
		dl_addr = '0;
		dl_data = '0;
		load_req = 1'b0;
		save_req = 1'b0;
		autosave_off = 1'b0;
		osd_open = 1'b0;
		img_mounted = 1'b0;
		img_readonly = 1'b0;
		img_size = '0;
		bk_pending = 1'b0;
		save_type = loader_pkg::save_none;
		load_stimulus();
		loaded = 1'b1;
		wait (rst_n);
		@(negedge clk_1x);
		check("reset", 32'd0, 32'(dl_wait));
		check("reset", 32'd0, 32'(use_img));
		check("reset", 32'd0, 32'(cart_loaded));
		check("reset", 32'd0, 32'(led_user));
		// Busy save engine lights the LED outside a download
		@(posedge clk_1x);
		bk_pending <= 1'b1;
		@(negedge clk_1x);
		check("led_busy", 32'd1, 32'(led_user));
		@(posedge clk_1x);
		bk_pending <= 1'b0;
		@(negedge clk_1x);
		check("led_busy", 32'd0, 32'(led_user));
		for (int i = 0; i < n_lines; i++) begin
			if (cmd_tab[i] == "pif") pif_download(i);
			else if (cmd_tab[i] == "cart") cart_download(i);
			else if (cmd_tab[i] == "backup") backup_sequence(i);
			else if (cmd_tab[i] == "savetype") save_type_decode(i);
			else report_failure("unknown command in the stimulus file");
		end
		repeat (4) @(posedge clk_1x);
		// Every cartridge word pair gave exactly one RAM request
		check("req_count", 32'(pairs_sent), 32'(req_count));
		$display("Regression passed");
		$finish;
	end

endmodule
